/* verilog/mspe_cfg.svh */
`ifndef MSPE_CFG_SVH
`define MSPE_CFG_SVH

// number of processing cores.
`define MSPE_CORES 4

// stream word width in bits.
`define MSPE_WORD_W 64

// longest payload a header may announce.
`define MSPE_MAX_LEN 255

`endif

/* verilog/mspe_pkg.sv */
package mspe_pkg;

`include "mspe_cfg.svh"

    // core index and per-core masks.
    typedef logic [$clog2(`MSPE_CORES)-1:0] core_id_t;
    typedef logic [`MSPE_CORES-1:0]         core_mask_t;

    typedef logic [`MSPE_WORD_W-1:0] word_t;
    typedef logic [31:0]             mem_addr_t;
    typedef logic [31:0]             coef_t;
    typedef logic [15:0]             pkt_len_t;

    // allocator waits for a request, then for the pointed core.
    typedef enum logic {
        alloc_idle,
        alloc_grant
    } alloc_state_t;

endpackage

/* verilog/core_simple_assignment.sv */
`timescale 1ns/1ps

module core_simple_assignment import mspe_pkg::*; (
    input  logic     clk,
    input  logic     rst_n_i,
    input  logic     soft_rst_i,
    input  logic     core_request_i,
    input  logic     core_release_i,
    input  core_id_t released_core_id_i,
    output logic     core_valid_o,
    output core_id_t core_id_o
);

    alloc_state_t state;
    core_mask_t   busy;
    core_mask_t   set_mask;
    core_mask_t   clr_mask;
    core_id_t     ptr;
    logic         grant;

    // strict round robin, the pointed core is granted once free.
    assign grant = (state == alloc_grant) && !busy[ptr];

    always_comb begin
        set_mask = '0;
        clr_mask = '0;
        set_mask[ptr] = grant;
        clr_mask[released_core_id_i] = core_release_i;
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state        <= alloc_idle;
            busy         <= '0;
            ptr          <= '0;
            core_valid_o <= 1'b0;
            core_id_o    <= '0;
        end else if (soft_rst_i) begin
            state <= alloc_idle;
            {busy, ptr, core_valid_o, core_id_o} <= '0;
        end else begin
            busy         <= (busy & ~clr_mask) | set_mask;
            core_valid_o <= grant;
            case (state)
                alloc_idle: begin
                    if (core_request_i) begin
                        state <= alloc_grant;
                    end
                end
                alloc_grant: begin
                    if (grant) begin
                        core_id_o <= ptr;
                        ptr       <= ptr + 1'b1;
                        state     <= alloc_idle;
                    end
                end
                default: state <= alloc_idle;
            endcase
        end
    end

    // a core handed back by the top level was granted before.
    assert property (@(posedge clk) disable iff (!rst_n_i || soft_rst_i)
        core_release_i |-> busy[released_core_id_i]);

endmodule

/* verilog/core_simple_queue.sv */
`timescale 1ns/1ps
`include "mspe_cfg.svh"

module core_simple_queue import mspe_pkg::*; (
    input  logic     clk,
    input  logic     rst_n_i,
    input  logic     soft_rst_i,
    input  core_id_t enqueue_id_i,
    input  logic     enqueue_valid_i,
    output core_id_t current_id_o,
    output logic     current_valid_o,
    input  logic     current_consume_i
);

    localparam int queue_depth = `MSPE_CORES;

    core_id_t                     slots [queue_depth];
    core_id_t                     wr_ptr;
    core_id_t                     rd_ptr;
    logic [$clog2(queue_depth):0] count;
    logic                         pop;

    assign current_valid_o = (count != '0);
    assign current_id_o    = slots[rd_ptr];
    assign pop             = current_consume_i && current_valid_o;

    always_ff @(posedge clk) begin
        if (enqueue_valid_i) begin
            slots[wr_ptr] <= enqueue_id_i;
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (soft_rst_i) begin
            {wr_ptr, rd_ptr, count} <= '0;
        end else begin
            if (enqueue_valid_i) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + enqueue_valid_i - pop;
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n_i)
        enqueue_valid_i |-> (count < queue_depth) || pop);

    assert property (@(posedge clk) disable iff (!rst_n_i)
        current_consume_i |-> current_valid_o);

endmodule

/* verilog/stream_data_parser.sv */
`timescale 1ns/1ps
`include "mspe_cfg.svh"

module stream_data_parser import mspe_pkg::*; (
    input  logic        clk,
    input  logic        rst_n_i,
    input  logic        soft_rst_i,
    output logic        recv_fifo_rdreq_o,
    input  word_t       recv_fifo_q_i,
    input  logic [10:0] recv_fifo_rdusedw_i,
    input  logic        recv_fifo_valid_i,
    output logic        core_request_o,
    input  logic        core_valid_i,
    input  core_id_t    core_id_i,
    output core_id_t    target_core_o,
    output logic        snk_sop_o,
    output logic        snk_eop_o,
    output logic        snk_valid_o,
    output word_t       snk_data_o,
    output logic        loader_enqueue_o,
    output mem_addr_t   loader_base_addr_o
);

    typedef enum logic [1:0] {
        p_head,
        p_grant,
        p_body
    } parse_state_t;

    parse_state_t state;
    pkt_len_t     pkt_len;
    pkt_len_t     req_left;
    pkt_len_t     rcv_left;
    logic         can_read;

    // a request still in flight owns one of the words rdusedw reports.
    assign can_read = recv_fifo_rdusedw_i > {10'b0, recv_fifo_rdreq_o};

    always_ff @(posedge clk) begin
        if (recv_fifo_valid_i) begin
            snk_data_o <= recv_fifo_q_i;
        end
        if (state == p_head && recv_fifo_valid_i) begin
            pkt_len            <= recv_fifo_q_i[15:0];
            loader_base_addr_o <= recv_fifo_q_i[63:32];
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state             <= p_head;
            req_left          <= '0;
            rcv_left          <= '0;
            recv_fifo_rdreq_o <= 1'b0;
            core_request_o    <= 1'b0;
            loader_enqueue_o  <= 1'b0;
            target_core_o     <= '0;
            snk_valid_o       <= 1'b0;
            snk_sop_o         <= 1'b0;
            snk_eop_o         <= 1'b0;
        end else if (soft_rst_i) begin
            state <= p_head;
            {req_left, rcv_left, recv_fifo_rdreq_o, core_request_o} <= '0;
            {loader_enqueue_o, target_core_o, snk_valid_o, snk_sop_o, snk_eop_o} <= '0;
        end else begin
            recv_fifo_rdreq_o <= 1'b0;
            core_request_o    <= 1'b0;
            loader_enqueue_o  <= 1'b0;
            snk_valid_o       <= 1'b0;
            case (state)
                p_head: begin
                    if (recv_fifo_valid_i) begin
                        core_request_o <= 1'b1;
                        state          <= p_grant;
                    end else if (!recv_fifo_rdreq_o && recv_fifo_rdusedw_i != '0) begin
                        recv_fifo_rdreq_o <= 1'b1;
                    end
                end
                // no reads until a core owns the payload.
                p_grant: begin
                    if (core_valid_i) begin
                        target_core_o    <= core_id_i;
                        loader_enqueue_o <= 1'b1;
                        req_left         <= pkt_len;
                        rcv_left         <= pkt_len;
                        state            <= p_body;
                    end
                end
                p_body: begin
                    if (req_left != '0 && can_read) begin
                        recv_fifo_rdreq_o <= 1'b1;
                        req_left          <= req_left - 1'b1;
                    end
                    if (recv_fifo_valid_i) begin
                        snk_valid_o <= 1'b1;
                        snk_sop_o   <= (rcv_left == pkt_len);
                        snk_eop_o   <= (rcv_left == 16'd1);
                        rcv_left    <= rcv_left - 1'b1;
                        if (rcv_left == 16'd1) begin
                            state <= p_head;
                        end
                    end
                end
                default: state <= p_head;
            endcase
        end
    end

    // header lengths outside this range would stall or overrun a core.
    assert property (@(posedge clk) disable iff (!rst_n_i)
        (state == p_head && recv_fifo_valid_i) |->
        (recv_fifo_q_i[15:0] != '0 && recv_fifo_q_i[15:0] <= `MSPE_MAX_LEN));

endmodule

/* verilog/data_loader.sv */
`timescale 1ns/1ps

module data_loader import mspe_pkg::*; (
    input  logic        clk,
    input  logic        rst_n_i,
    input  logic        soft_rst_i,
    input  logic        kick_i,
    input  mem_addr_t   base_addr_i,
    input  core_id_t    target_core_i,
    output logic        busy_o,
    output coef_t       coef_o,
    output core_mask_t  coef_we_o,
    input  logic        m0_waitrequest_i,
    input  logic [31:0] m0_readdata_i,
    input  logic        m0_readdatavalid_i,
    output logic [2:0]  m0_burstcount_o,
    output mem_addr_t   m0_address_o,
    output logic        m0_read_o,
    output logic [3:0]  m0_byteenable_o
);

    typedef enum logic [1:0] {
        ld_idle,
        ld_req,
        ld_wait
    } load_state_t;

    load_state_t state;
    core_id_t    target;

    assign busy_o          = (state != ld_idle);
    assign m0_burstcount_o = 3'd1;
    assign m0_byteenable_o = 4'hf;

    always_ff @(posedge clk) begin
        if (state == ld_idle && kick_i) begin
            m0_address_o <= base_addr_i;
            target       <= target_core_i;
        end
        if (state == ld_wait && m0_readdatavalid_i) begin
            coef_o <= m0_readdata_i;
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state     <= ld_idle;
            m0_read_o <= 1'b0;
            coef_we_o <= '0;
        end else if (soft_rst_i) begin
            state <= ld_idle;
            {m0_read_o, coef_we_o} <= '0;
        end else begin
            coef_we_o <= '0;
            case (state)
                ld_idle: begin
                    if (kick_i) begin
                        m0_read_o <= 1'b1;
                        state     <= ld_req;
                    end
                end
                // held until the slave accepts.
                ld_req: begin
                    if (!m0_waitrequest_i) begin
                        m0_read_o <= 1'b0;
                        state     <= ld_wait;
                    end
                end
                ld_wait: begin
                    if (m0_readdatavalid_i) begin
                        coef_we_o[target] <= 1'b1;
                        state             <= ld_idle;
                    end
                end
                default: state <= ld_idle;
            endcase
        end
    end

    // a stalled read keeps its request and address.
    assert property (@(posedge clk) disable iff (!rst_n_i || soft_rst_i)
        (m0_read_o && m0_waitrequest_i) |=> (m0_read_o && $stable(m0_address_o)));

endmodule

/* verilog/sum_core.sv */
`timescale 1ns/1ps

module sum_core import mspe_pkg::*; (
    input  logic  clk,
    input  logic  rst_n_i,
    input  logic  core_reset_i,
    input  logic  run_i,
    input  coef_t coef_i,
    input  logic  coef_we_i,
    input  logic  snk_valid_i,
    input  logic  snk_sop_i,
    input  logic  snk_eop_i,
    input  word_t snk_data_i,
    output logic  halt_o,
    input  logic  src_req_i,
    input  logic  src_ready_i,
    output logic  src_valid_o,
    output logic  src_sop_o,
    output logic  src_eop_o,
    output word_t src_q_o
);

    word_t    sum;
    word_t    product;
    pkt_len_t count;
    coef_t    coef;
    logic     run_seen;
    logic     eop_seen;
    logic     beat;

    // halts once both run and the last payload word have arrived.
    assign halt_o    = run_seen && eop_seen;
    assign product   = sum * word_t'(coef);
    assign src_sop_o = src_valid_o && !beat;
    assign src_eop_o = src_valid_o && beat;
    assign src_q_o   = beat ? product : {16'b0, count, coef};

    always_ff @(posedge clk) begin
        if (coef_we_i) begin
            coef <= coef_i;
        end
        if (snk_valid_i) begin
            sum   <= snk_sop_i ? snk_data_i : sum + snk_data_i;
            count <= snk_sop_i ? 16'd1 : count + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            run_seen    <= 1'b0;
            eop_seen    <= 1'b0;
            src_valid_o <= 1'b0;
            beat        <= 1'b0;
        end else if (core_reset_i) begin
            {run_seen, eop_seen, src_valid_o, beat} <= '0;
        end else begin
            if (run_i) begin
                run_seen <= 1'b1;
            end
            if (snk_valid_i && snk_eop_i) begin
                eop_seen <= 1'b1;
            end
            if (src_req_i) begin
                src_valid_o <= 1'b1;
                beat        <= 1'b0;
            end else if (src_valid_o && src_ready_i) begin
                // second beat accepted ends the packet.
                src_valid_o <= !beat;
                beat        <= !beat;
            end
        end
    end

endmodule

/* verilog/mspe.sv */
`timescale 1ns/1ps
`include "mspe_cfg.svh"

module mspe import mspe_pkg::*; (
    input  logic        clk,
    input  logic        rst_n_i,
    input  logic        all_core_reset_i,
    output logic        recv_fifo_rdreq_o,
    input  word_t       recv_fifo_q_i,
    input  logic [10:0] recv_fifo_rdusedw_i,
    input  logic        recv_fifo_valid_i,
    input  logic        m0_waitrequest_i,
    input  logic [31:0] m0_readdata_i,
    input  logic        m0_readdatavalid_i,
    output logic [2:0]  m0_burstcount_o,
    output mem_addr_t   m0_address_o,
    output logic        m0_read_o,
    output logic [3:0]  m0_byteenable_o,
    output word_t       src_data_o,
    output logic        src_valid_o,
    output logic        src_sop_o,
    output logic        src_eop_o,
    input  logic        src_ready_i,
    output core_mask_t  core_status_o
);

    core_mask_t core_halt;
    core_mask_t core_run;
    core_mask_t core_reset;
    core_mask_t core_snk_valid;
    core_mask_t core_src_req;
    core_mask_t core_src_valid;
    core_mask_t core_src_sop;
    core_mask_t core_src_eop;
    core_mask_t head_mask;
    word_t      core_src_q [`MSPE_CORES];
    coef_t      coef;
    core_mask_t coef_we;

    logic       core_request;
    logic       core_valid;
    core_id_t   core_id;
    core_id_t   target_core;
    logic       snk_sop;
    logic       snk_eop;
    logic       snk_valid;
    word_t      snk_data;
    logic       loader_enqueue;
    mem_addr_t  enqueue_base_addr;
    mem_addr_t  base_pool [`MSPE_CORES];

    logic       loader_kick;
    logic       loader_busy;
    logic       busy_d1;
    logic       busy_d2;
    logic       busy_d3;
    core_id_t   loader_target_core;
    mem_addr_t  loader_base_addr;
    core_id_t   cur_loader_id;
    logic       cur_loader_valid;
    logic       load_fall;
    logic       load_done;

    core_id_t   run_enqueue_id;
    core_id_t   cur_run_id;
    logic       cur_run_valid;
    logic       cur_core_halt;
    logic       eop_accept;
    logic       run_done;
    logic       src_req;
    logic       src_req_done;

    for (genvar i = 0; i < `MSPE_CORES; i++) begin : g_core
        sum_core u_core (
            .clk          (clk),
            .rst_n_i      (rst_n_i),
            .core_reset_i (core_reset[i] | all_core_reset_i),
            .run_i        (core_run[i]),
            .coef_i       (coef),
            .coef_we_i    (coef_we[i]),
            .snk_valid_i  (core_snk_valid[i]),
            .snk_sop_i    (snk_sop),
            .snk_eop_i    (snk_eop),
            .snk_data_i   (snk_data),
            .halt_o       (core_halt[i]),
            .src_req_i    (core_src_req[i]),
            .src_ready_i  (src_ready_i),
            .src_valid_o  (core_src_valid[i]),
            .src_sop_o    (core_src_sop[i]),
            .src_eop_o    (core_src_eop[i]),
            .src_q_o      (core_src_q[i])
        );
    end

    core_simple_assignment u_assign (
        .clk                (clk),
        .rst_n_i            (rst_n_i),
        .soft_rst_i         (all_core_reset_i),
        .core_request_i     (core_request),
        .core_release_i     (run_done),
        .released_core_id_i (cur_run_id),
        .core_valid_o       (core_valid),
        .core_id_o          (core_id)
    );

    stream_data_parser u_parser (
        .clk                 (clk),
        .rst_n_i             (rst_n_i),
        .soft_rst_i          (all_core_reset_i),
        .recv_fifo_rdreq_o   (recv_fifo_rdreq_o),
        .recv_fifo_q_i       (recv_fifo_q_i),
        .recv_fifo_rdusedw_i (recv_fifo_rdusedw_i),
        .recv_fifo_valid_i   (recv_fifo_valid_i),
        .core_request_o      (core_request),
        .core_valid_i        (core_valid),
        .core_id_i           (core_id),
        .target_core_o       (target_core),
        .snk_sop_o           (snk_sop),
        .snk_eop_o           (snk_eop),
        .snk_valid_o         (snk_valid),
        .snk_data_o          (snk_data),
        .loader_enqueue_o    (loader_enqueue),
        .loader_base_addr_o  (enqueue_base_addr)
    );

    core_simple_queue u_loader_queue (
        .clk               (clk),
        .rst_n_i           (rst_n_i),
        .soft_rst_i        (all_core_reset_i),
        .enqueue_id_i      (target_core),
        .enqueue_valid_i   (loader_enqueue),
        .current_id_o      (cur_loader_id),
        .current_valid_o   (cur_loader_valid),
        .current_consume_i (load_done)
    );

    core_simple_queue u_run_queue (
        .clk               (clk),
        .rst_n_i           (rst_n_i),
        .soft_rst_i        (all_core_reset_i),
        .enqueue_id_i      (run_enqueue_id),
        .enqueue_valid_i   (load_done),
        .current_id_o      (cur_run_id),
        .current_valid_o   (cur_run_valid),
        .current_consume_i (run_done)
    );

    data_loader u_loader (
        .clk                (clk),
        .rst_n_i            (rst_n_i),
        .soft_rst_i         (all_core_reset_i),
        .kick_i             (loader_kick),
        .base_addr_i        (loader_base_addr),
        .target_core_i      (loader_target_core),
        .busy_o             (loader_busy),
        .coef_o             (coef),
        .coef_we_o          (coef_we),
        .m0_waitrequest_i   (m0_waitrequest_i),
        .m0_readdata_i      (m0_readdata_i),
        .m0_readdatavalid_i (m0_readdatavalid_i),
        .m0_burstcount_o    (m0_burstcount_o),
        .m0_address_o       (m0_address_o),
        .m0_read_o          (m0_read_o),
        .m0_byteenable_o    (m0_byteenable_o)
    );

    // the run queue head owns the output stream.
    assign src_data_o    = core_src_q[cur_run_id];
    assign src_valid_o   = cur_run_valid && core_src_valid[cur_run_id];
    assign src_sop_o     = cur_run_valid && core_src_sop[cur_run_id];
    assign src_eop_o     = cur_run_valid && core_src_eop[cur_run_id];
    assign cur_core_halt = core_halt[cur_run_id];
    assign core_status_o = core_halt;
    assign load_fall     = cur_loader_valid && !loader_busy && busy_d1;
    assign eop_accept    = src_valid_o && src_eop_o && src_ready_i;

    always_comb begin
        core_snk_valid = '0;
        core_run       = '0;
        core_src_req   = '0;
        head_mask      = '0;
        core_snk_valid[target_core] = snk_valid;
        core_run[run_enqueue_id]    = load_done;
        core_src_req[cur_run_id]    = src_req;
        head_mask[cur_run_id]       = cur_run_valid;
    end

    always_ff @(posedge clk) begin
        if (loader_enqueue) begin
            base_pool[target_core] <= enqueue_base_addr;
        end
        loader_target_core <= cur_loader_id;
        loader_base_addr   <= base_pool[cur_loader_id];
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            loader_kick    <= 1'b0;
            busy_d1        <= 1'b0;
            busy_d2        <= 1'b0;
            busy_d3        <= 1'b0;
            load_done      <= 1'b0;
            run_enqueue_id <= '0;
            run_done       <= 1'b0;
            src_req        <= 1'b0;
            src_req_done   <= 1'b0;
            core_reset     <= '0;
        end else if (all_core_reset_i) begin
            {loader_kick, busy_d1, busy_d2, busy_d3, load_done} <= '0;
            {run_done, src_req, src_req_done} <= '0;
            run_enqueue_id <= '0;
            core_reset     <= '0;
        end else begin
            busy_d1 <= loader_busy;
            busy_d2 <= busy_d1;
            busy_d3 <= busy_d2;
            // kick only after three quiet loader cycles.
            loader_kick <= cur_loader_valid && !loader_kick &&
                           !(loader_busy || busy_d1 || busy_d2 || busy_d3);
            load_done <= load_fall;
            if (load_fall) begin
                run_enqueue_id <= cur_loader_id;
            end
            run_done <= eop_accept;
            src_req  <= 1'b0;
            if (run_done) begin
                src_req_done <= 1'b0;
            end else if (cur_run_valid && cur_core_halt && !src_req_done) begin
                src_req      <= 1'b1;
                src_req_done <= 1'b1;
            end
            core_reset <= '0;
            if (run_done) begin
                core_reset[cur_run_id] <= 1'b1;
            end
        end
    end

    // no core other than the run queue head drives a beat.
    assert property (@(posedge clk) disable iff (!rst_n_i)
        (core_src_valid & ~head_mask) == '0);

endmodule

/* verification/mspe_tb.sv */
`timescale 1ns/1ps

module mspe_tb import mspe_pkg::*; ();

    logic        clk = 1'b0;
    logic        rst_n_i;
    logic        all_core_reset_i;
    logic        recv_fifo_rdreq_o;
    word_t       recv_fifo_q_i;
    logic [10:0] recv_fifo_rdusedw_i;
    logic        recv_fifo_valid_i;
    logic        m0_waitrequest_i;
    logic [31:0] m0_readdata_i;
    logic        m0_readdatavalid_i;
    logic [2:0]  m0_burstcount_o;
    mem_addr_t   m0_address_o;
    logic        m0_read_o;
    logic [3:0]  m0_byteenable_o;
    word_t       src_data_o;
    logic        src_valid_o;
    logic        src_sop_o;
    logic        src_eop_o;
    logic        src_ready_i;
    core_mask_t  core_status_o;

    logic [31:0] rng_state = 32'd77;
    int          errors = 0;
    logic        stall_en = 1'b0;

    // receive FIFO model.
    word_t       fifo_q [$];
    logic        fifo_pending = 1'b0;

    // memory model phases are 0 idle, 1 command and 2 data latency.
    coef_t       mem [mem_addr_t];
    logic [1:0]  mem_phase = 2'd0;
    int          wait_left;
    int          lat_left;
    mem_addr_t   rd_addr;

    word_t       exp_beats [$];
    logic        beat_odd = 1'b0;

    always #50 clk = ~clk;

    mspe u_mspe (
        .clk                 (clk),
        .rst_n_i             (rst_n_i),
        .all_core_reset_i    (all_core_reset_i),
        .recv_fifo_rdreq_o   (recv_fifo_rdreq_o),
        .recv_fifo_q_i       (recv_fifo_q_i),
        .recv_fifo_rdusedw_i (recv_fifo_rdusedw_i),
        .recv_fifo_valid_i   (recv_fifo_valid_i),
        .m0_waitrequest_i    (m0_waitrequest_i),
        .m0_readdata_i       (m0_readdata_i),
        .m0_readdatavalid_i  (m0_readdatavalid_i),
        .m0_burstcount_o     (m0_burstcount_o),
        .m0_address_o        (m0_address_o),
        .m0_read_o           (m0_read_o),
        .m0_byteenable_o     (m0_byteenable_o),
        .src_data_o          (src_data_o),
        .src_valid_o         (src_valid_o),
        .src_sop_o           (src_sop_o),
        .src_eop_o           (src_eop_o),
        .src_ready_i         (src_ready_i),
        .core_status_o       (core_status_o)
    );

    function automatic logic [31:0] xorshift();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    // beat 0 carries count and coefficient and beat 1 the scaled sum.
    function automatic void expected_beats(input word_t payload [$], input coef_t coef,
                                           output word_t beat0, output word_t beat1);
        word_t    acc;
        pkt_len_t n;
        acc = '0;
        n = pkt_len_t'(payload.size());
        foreach (payload[i]) begin
            acc = acc + payload[i];
        end
        beat0 = {16'h0, n, coef};
        beat1 = acc * {32'h0, coef};
    endfunction

    task automatic finish_run();
        if (errors == 0) begin
            $display("Done: no errors");
            $finish;
        end else begin
            $display("Done: errors found");
            $fatal(1);
        end
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        errors++;
        finish_run();
    endtask

    task automatic check_word(input string name, input word_t act, input word_t exp);
        if (act !== exp) begin
            $display("** Error: %s = 0x%h, expected 0x%h", name, act, exp);
            errors++;
            finish_run();
        end
    endtask

    task automatic check_flag(input string name, input logic act, input logic exp);
        if (act !== exp) begin
            $display("** Error: %s = 0x%h, expected 0x%h", name, act, exp);
            errors++;
            finish_run();
        end
    endtask

    task automatic check_mask(input string name, input core_mask_t act,
                              input core_mask_t exp);
        if (act !== exp) begin
            $display("** Error: %s = 0x%h, expected 0x%h", name, act, exp);
            errors++;
            finish_run();
        end
    endtask

    task automatic check_field(input string name, input logic [3:0] act,
                               input logic [3:0] exp);
        if (act !== exp) begin
            $display("** Error: %s = 0x%h, expected 0x%h", name, act, exp);
            errors++;
            finish_run();
        end
    endtask

    task automatic send_packet(input pkt_len_t len);
        word_t     payload [$];
        word_t     word;
        word_t     beat0;
        word_t     beat1;
        mem_addr_t base;
        base = xorshift() & 32'hffff_fffc;
        if (!mem.exists(base)) begin
            mem[base] = xorshift();
        end
        fifo_q.push_back({base, 16'h0, len});
        for (int i = 0; i < len; i++) begin
            word = {xorshift(), xorshift()};
            payload.push_back(word);
            fifo_q.push_back(word);
        end
        expected_beats(payload, mem[base], beat0, beat1);
        exp_beats.push_back(beat0);
        exp_beats.push_back(beat1);
    endtask

    task automatic send_random(input int count);
        for (int i = 0; i < count; i++) begin
            send_packet(pkt_len_t'(xorshift() % 20 + 1));
        end
    endtask

    task automatic wait_idle(input int limit);
        int cycles;
        cycles = 0;
        while (fifo_q.size() != 0 || fifo_pending || exp_beats.size() != 0 ||
               core_status_o != '0) begin
            @(posedge clk);
            cycles++;
            if (cycles > limit) begin
                abort_run("timeout waiting for the engine to drain");
            end
        end
    endtask

    // models and the beat compare run on the falling edge.
    always @(negedge clk) begin
        word_t beat_exp;
        recv_fifo_valid_i = fifo_pending;
        if (fifo_pending) begin
            if (fifo_q.size() == 0) begin
                abort_run("receive FIFO was read while empty");
            end
            recv_fifo_q_i = fifo_q.pop_front();
        end
        fifo_pending = recv_fifo_rdreq_o;
        recv_fifo_rdusedw_i = 11'(fifo_q.size());

        m0_readdatavalid_i = 1'b0;
        if (mem_phase == 2'd2) begin
            if (lat_left == 0) begin
                if (!mem.exists(rd_addr)) begin
                    abort_run("memory read from an address that holds no coefficient");
                end
                m0_readdatavalid_i = 1'b1;
                m0_readdata_i      = mem[rd_addr];
                mem_phase          = 2'd0;
            end else begin
                lat_left--;
            end
        end
        if (mem_phase == 2'd0 && m0_read_o) begin
            wait_left = stall_en ? int'(xorshift() % 4) : 0;
            mem_phase = 2'd1;
        end
        if (mem_phase == 2'd1) begin
            if (wait_left != 0) begin
                m0_waitrequest_i = 1'b1;
                wait_left--;
            end else begin
                check_field("m0_burstcount_o", {1'b0, m0_burstcount_o}, 4'd1);
                check_field("m0_byteenable_o", m0_byteenable_o, 4'hf);
                m0_waitrequest_i = 1'b0;
                rd_addr          = m0_address_o;
                lat_left         = stall_en ? int'(xorshift() % 5) : 0;
                mem_phase        = 2'd2;
            end
        end else begin
            m0_waitrequest_i = 1'b1;
        end

        // a beat is taken at the next rising edge.
        src_ready_i = stall_en ? (xorshift() % 4 != 0) : 1'b1;
        if (src_valid_o && src_ready_i) begin
            if (exp_beats.size() == 0) begin
                abort_run("output beat arrived with no packet outstanding");
            end
            beat_exp = exp_beats.pop_front();
            check_flag("src_sop_o", src_sop_o, !beat_odd);
            check_flag("src_eop_o", src_eop_o, beat_odd);
            check_word("src_data_o", src_data_o, beat_exp);
            beat_odd = !beat_odd;
        end
    end

    initial begin
        rst_n_i             = 1'b0;
        all_core_reset_i    = 1'b0;
        recv_fifo_q_i       = '0;
        recv_fifo_rdusedw_i = '0;
        recv_fifo_valid_i   = 1'b0;
        m0_waitrequest_i    = 1'b1;
        m0_readdata_i       = '0;
        m0_readdatavalid_i  = 1'b0;
        src_ready_i         = 1'b0;
        repeat (4) @(negedge clk);
        check_flag("recv_fifo_rdreq_o", recv_fifo_rdreq_o, 1'b0);
        check_flag("m0_read_o", m0_read_o, 1'b0);
        check_flag("src_valid_o", src_valid_o, 1'b0);
        check_mask("core_status_o", core_status_o, '0);
        rst_n_i = 1'b1;
        wait_idle(100);

        // one word packet.
        @(posedge clk);
        send_packet(16'd1);
        wait_idle(1000);

        // wrap around and reuse of every core.
        send_random(12);
        wait_idle(8000);

        // output back pressure and slow memory.
        stall_en = 1'b1;
        send_random(12);
        wait_idle(8000);

        @(negedge clk);
        all_core_reset_i = 1'b1;
        @(negedge clk);
        all_core_reset_i = 1'b0;
        @(posedge clk);
        send_packet(16'd5);
        wait_idle(2000);

        finish_run();
    end

endmodule

/* list.f */
+incdir+verilog
verilog/mspe_pkg.sv
verilog/core_simple_assignment.sv
verilog/core_simple_queue.sv
verilog/stream_data_parser.sv
verilog/data_loader.sv
verilog/sum_core.sv
verilog/mspe.sv
verification/mspe_tb.sv

/* Bender.yml */
package:
  name: mspe

export_include_dirs:
  - verilog

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/mspe_pkg.sv
      - verilog/core_simple_assignment.sv
      - verilog/core_simple_queue.sv
      - verilog/stream_data_parser.sv
      - verilog/data_loader.sv
      - verilog/sum_core.sv
      - verilog/mspe.sv
  - target: simulation
    files:
      - verification/mspe_tb.sv
